//--- compile.f
+incdir+include
rtl/exc_pkg.sv
rtl/rob_pkg.sv
rtl/rob_entry.sv
rtl/rob_commit.sv
rtl/rob.sv
verification/tb_rob.sv

//--- include/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// ROB geometry
`define ROB_ENTRIES 8
`define ROB_IDX_W   3

// Dispatch group and slot index width
`define DISP_W      2
`define SLOT_W      1

// Execution ports reporting completion
`define CMPL_PORTS  2

// Address and data widths
`define PC_W        32
`define TVAL_W      32

`endif

//--- rtl/exc_pkg.sv
package exc_pkg;

`include "rob_cfg.svh"

  // Architectural trap causes, 3 bits wide
  typedef enum logic [2:0] {
    EXC_NONE        = 3'd0,
    EXC_FETCH_FAULT = 3'd1,
    EXC_ILLEGAL     = 3'd2,
    EXC_LOAD_FAULT  = 3'd3,
    EXC_STORE_FAULT = 3'd4,
    EXC_ECALL       = 3'd5
  } except_t;

  typedef logic [`TVAL_W-1:0] tval_t;  // Trap value

endpackage

//--- rtl/rob.sv
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob import exc_pkg::*, rob_pkg::*; (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_disp_valid,
  input  logic [`PC_W-1:0]             i_disp_pc,
  input  grp_mask_t                    i_disp_grp,
  input  grp_mask_t                    i_disp_illegal,
  input  grp_mask_t                    i_disp_fetch_fault,
  output rob_idx_t                     o_disp_id,
  output logic                         o_full,

  input  logic [`CMPL_PORTS-1:0]       i_cmpl_valid,
  input  rob_idx_t [`CMPL_PORTS-1:0]   i_cmpl_id,
  input  slot_idx_t [`CMPL_PORTS-1:0]  i_cmpl_slot,
  input  logic [`CMPL_PORTS-1:0]       i_cmpl_except,
  input  except_t [`CMPL_PORTS-1:0]    i_cmpl_cause,
  input  tval_t [`CMPL_PORTS-1:0]      i_cmpl_tval,

  output logic                         o_commit_valid,
  output rob_idx_t                     o_commit_id,
  output logic [`PC_W-1:0]             o_commit_pc,
  output grp_mask_t                    o_commit_retire,
  output logic                         o_commit_except,
  output except_t                      o_commit_cause,
  output tval_t                        o_commit_tval,
  output slot_idx_t                    o_commit_slot,
  output logic                         o_kill
);

  rob_idx_t                r_head;
  rob_idx_t                r_tail;
  logic [`ROB_IDX_W:0]     r_count;

  logic                    w_advance;
  logic                    w_commit_finish;
  logic [`ROB_ENTRIES-1:0] w_valid;
  logic [`ROB_ENTRIES-1:0] w_all_done;
  logic [`PC_W-1:0]        w_pc     [`ROB_ENTRIES];
  grp_mask_t               w_grp    [`ROB_ENTRIES];
  grp_mask_t               w_dead   [`ROB_ENTRIES];
  grp_mask_t               w_except [`ROB_ENTRIES];
  except_t [`DISP_W-1:0]   w_cause  [`ROB_ENTRIES];
  tval_t [`DISP_W-1:0]     w_tval   [`ROB_ENTRIES];

  function automatic rob_idx_t inc_idx(rob_idx_t idx);
    return (idx == rob_idx_t'(`ROB_ENTRIES - 1)) ? '0 : idx + 1'b1;
  endfunction

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (i_disp_valid) r_tail <= inc_idx(r_tail);
      if (w_advance)    r_head <= inc_idx(r_head);
      r_count <= r_count + i_disp_valid - w_advance;
    end
  end

  assign o_disp_id = r_tail;  // Tag for completions
  assign o_full    = (r_count == (`ROB_IDX_W+1)'(`ROB_ENTRIES));

  for (genvar e = 0; e < `ROB_ENTRIES; e++) begin : g_entry
    rob_entry u_entry (
      .i_clk              (i_clk),
      .i_reset_n          (i_reset_n),
      .i_cmt_id           (rob_idx_t'(e)),
      .i_load             (i_disp_valid && (r_tail == rob_idx_t'(e))),
      .i_load_pc          (i_disp_pc),
      .i_load_grp         (i_disp_grp),
      .i_load_illegal     (i_disp_illegal),
      .i_load_fetch_fault (i_disp_fetch_fault),
      .i_cmpl_valid       (i_cmpl_valid),
      .i_cmpl_id          (i_cmpl_id),
      .i_cmpl_slot        (i_cmpl_slot),
      .i_cmpl_except      (i_cmpl_except),
      .i_cmpl_cause       (i_cmpl_cause),
      .i_cmpl_tval        (i_cmpl_tval),
      .i_kill             (o_kill),
      .i_commit_finish    (w_commit_finish && (r_head == rob_idx_t'(e))),
      .o_valid            (w_valid[e]),
      .o_all_done         (w_all_done[e]),
      .o_pc               (w_pc[e]),
      .o_grp              (w_grp[e]),
      .o_dead             (w_dead[e]),
      .o_except           (w_except[e]),
      .o_cause            (w_cause[e]),
      .o_tval             (w_tval[e])
    );
  end

  // Head entry feeds the commit unit
  rob_commit u_commit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_head_id       (r_head),
    .i_head_valid    (w_valid[r_head]),
    .i_head_all_done (w_all_done[r_head]),
    .i_head_pc       (w_pc[r_head]),
    .i_head_grp      (w_grp[r_head]),
    .i_head_dead     (w_dead[r_head]),
    .i_head_except   (w_except[r_head]),
    .i_head_cause    (w_cause[r_head]),
    .i_head_tval     (w_tval[r_head]),
    .o_commit_finish (w_commit_finish),
    .o_advance       (w_advance),
    .o_kill          (o_kill),
    .o_commit_valid  (o_commit_valid),
    .o_commit_id     (o_commit_id),
    .o_commit_pc     (o_commit_pc),
    .o_commit_retire (o_commit_retire),
    .o_commit_except (o_commit_except),
    .o_commit_cause  (o_commit_cause),
    .o_commit_tval   (o_commit_tval),
    .o_commit_slot   (o_commit_slot)
  );

  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> !o_full);

  // Occupancy count tracks the live entries
  a_count_match: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $countones(w_valid) == int'(r_count));

endmodule

//--- rtl/rob_commit.sv
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob_commit import exc_pkg::*, rob_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_reset_n,

  input  rob_idx_t               i_head_id,
  input  logic                   i_head_valid,
  input  logic                   i_head_all_done,
  input  logic [`PC_W-1:0]       i_head_pc,
  input  grp_mask_t              i_head_grp,
  input  grp_mask_t              i_head_dead,
  input  grp_mask_t              i_head_except,
  input  except_t [`DISP_W-1:0]  i_head_cause,
  input  tval_t [`DISP_W-1:0]    i_head_tval,

  output logic                   o_commit_finish,
  output logic                   o_advance,
  output logic                   o_kill,

  output logic                   o_commit_valid,
  output rob_idx_t               o_commit_id,
  output logic [`PC_W-1:0]       o_commit_pc,
  output grp_mask_t              o_commit_retire,
  output logic                   o_commit_except,
  output except_t                o_commit_cause,
  output tval_t                  o_commit_tval,
  output slot_idx_t              o_commit_slot
);

  commit_state_t r_state;

  grp_mask_t  w_live;
  grp_mask_t  w_exc_vec;
  grp_mask_t  w_retire;
  logic       w_exc;
  slot_idx_t  w_exc_slot;
  logic       w_decide;

  // Lowest live excepting slot bounds the retire mask
  always_comb begin
    w_live     = i_head_grp & ~i_head_dead;
    w_exc_vec  = w_live & i_head_except;
    w_exc      = |w_exc_vec;
    w_exc_slot = '0;
    w_retire   = w_live;
    for (int s = `DISP_W - 1; s >= 0; s--) begin
      if (w_exc_vec[s]) begin
        w_exc_slot = slot_idx_t'(s);
        w_retire   = w_live & grp_mask_t'((1 << s) - 1);
      end
    end
  end

  assign w_decide        = (r_state == COMMIT_RUN) && i_head_valid && i_head_all_done;
  assign o_commit_finish = w_decide;
  assign o_advance       = w_decide;
  assign o_kill          = (r_state == COMMIT_KILL);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state        <= COMMIT_RUN;
      o_commit_valid <= 1'b0;
    end else begin
      o_commit_valid <= w_decide;
      case (r_state)
        COMMIT_RUN:  if (w_decide && w_exc) r_state <= COMMIT_KILL;
        COMMIT_KILL: r_state <= COMMIT_RUN;  // One flush cycle
        default:     r_state <= COMMIT_RUN;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_decide) begin
      o_commit_id     <= i_head_id;
      o_commit_pc     <= i_head_pc;
      o_commit_retire <= w_retire;
      o_commit_except <= w_exc;
      o_commit_cause  <= w_exc ? i_head_cause[w_exc_slot] : EXC_NONE;
      o_commit_tval   <= w_exc ? i_head_tval[w_exc_slot] : '0;
      o_commit_slot   <= w_exc_slot;
    end
  end

  // Kill rides with its excepting commit and lasts one cycle
  a_kill_pulse: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_kill |-> (o_commit_valid && o_commit_except) ##1 !o_kill);

endmodule

//--- rtl/rob_entry.sv
`timescale 1ns/1ps

`include "rob_cfg.svh"

module rob_entry import exc_pkg::*, rob_pkg::*; (
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  rob_idx_t                     i_cmt_id,

  input  logic                         i_load,
  input  logic [`PC_W-1:0]             i_load_pc,
  input  grp_mask_t                    i_load_grp,
  input  grp_mask_t                    i_load_illegal,
  input  grp_mask_t                    i_load_fetch_fault,

  input  logic [`CMPL_PORTS-1:0]       i_cmpl_valid,
  input  rob_idx_t [`CMPL_PORTS-1:0]   i_cmpl_id,
  input  slot_idx_t [`CMPL_PORTS-1:0]  i_cmpl_slot,
  input  logic [`CMPL_PORTS-1:0]       i_cmpl_except,
  input  except_t [`CMPL_PORTS-1:0]    i_cmpl_cause,
  input  tval_t [`CMPL_PORTS-1:0]      i_cmpl_tval,

  input  logic                         i_kill,
  input  logic                         i_commit_finish,

  output logic                         o_valid,
  output logic                         o_all_done,
  output logic [`PC_W-1:0]             o_pc,
  output grp_mask_t                    o_grp,
  output grp_mask_t                    o_dead,
  output grp_mask_t                    o_except,
  output except_t [`DISP_W-1:0]        o_cause,
  output tval_t [`DISP_W-1:0]          o_tval
);

  logic                   r_valid;
  logic [`PC_W-1:0]       r_pc;
  grp_mask_t              r_grp;
  grp_mask_t              r_done;
  grp_mask_t              r_dead;
  grp_mask_t              r_except;
  except_t [`DISP_W-1:0]  r_cause;
  tval_t [`DISP_W-1:0]    r_tval;

  logic [`DISP_W-1:0][`CMPL_PORTS-1:0] w_hit;
  grp_mask_t              w_rpt_done;
  grp_mask_t              w_rpt_except;
  except_t [`DISP_W-1:0]  w_rpt_cause;
  tval_t [`DISP_W-1:0]    w_rpt_tval;
  grp_mask_t              w_pre_done;

  // Per slot, AND-OR select of the one port that reports it
  always_comb begin
    for (int s = 0; s < `DISP_W; s++) begin
      w_rpt_except[s] = 1'b0;
      w_rpt_cause[s]  = EXC_NONE;
      w_rpt_tval[s]   = '0;
      for (int p = 0; p < `CMPL_PORTS; p++) begin
        w_hit[s][p] = r_valid && i_cmpl_valid[p] && (i_cmpl_id[p] == i_cmt_id) &&
                      (i_cmpl_slot[p] == slot_idx_t'(s));
        w_rpt_except[s] = w_rpt_except[s] | (w_hit[s][p] & i_cmpl_except[p]);
        w_rpt_cause[s]  = except_t'(w_rpt_cause[s] |
                                    ({$bits(except_t){w_hit[s][p]}} & i_cmpl_cause[p]));
        w_rpt_tval[s]   = w_rpt_tval[s] | ({`TVAL_W{w_hit[s][p]}} & i_cmpl_tval[p]);
      end
      w_rpt_done[s] = |w_hit[s];
    end
  end

  // Faults known at dispatch need no execution
  assign w_pre_done = (i_load_illegal | i_load_fetch_fault) & i_load_grp;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= 1'b0;
      r_grp    <= '0;
      r_done   <= '0;
      r_dead   <= '0;
      r_except <= '0;
    end else if (i_load) begin
      r_valid  <= 1'b1;
      r_grp    <= i_load_grp;
      r_done   <= w_pre_done;
      r_except <= w_pre_done;
      r_dead   <= {`DISP_W{i_kill}};  // Loaded under kill is born dead
    end else if (r_valid) begin
      if (i_commit_finish) begin
        r_valid <= 1'b0;
      end
      r_done   <= r_done | w_rpt_done;
      r_except <= (r_except & ~w_rpt_done) | (w_rpt_done & w_rpt_except);
      r_dead   <= r_dead | {`DISP_W{i_kill}};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_pc <= i_load_pc;
      for (int s = 0; s < `DISP_W; s++) begin
        if (i_load_fetch_fault[s]) begin
          r_cause[s] <= EXC_FETCH_FAULT;
          r_tval[s]  <= tval_t'(i_load_pc);  // Faulting fetch address
        end else begin
          r_cause[s] <= i_load_illegal[s] ? EXC_ILLEGAL : EXC_NONE;
          r_tval[s]  <= '0;
        end
      end
    end else begin
      for (int s = 0; s < `DISP_W; s++) begin
        if (w_rpt_done[s]) begin
          r_cause[s] <= w_rpt_cause[s];
          r_tval[s]  <= w_rpt_tval[s];
        end
      end
    end
  end

  assign o_valid    = r_valid;
  assign o_all_done = r_valid && (((r_done | r_dead) & r_grp) == r_grp);
  assign o_pc       = r_pc;
  assign o_grp      = r_grp;
  assign o_dead     = r_dead;
  assign o_except   = r_except;
  assign o_cause    = r_cause;
  assign o_tval     = r_tval;

  // Execution ports must not finish the same slot twice at once
  for (genvar s = 0; s < `DISP_W; s++) begin : g_chk
    a_single_report: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      $onehot0(w_hit[s]));
  end

  a_no_overwrite: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_load && r_valid));

endmodule

//--- rtl/rob_pkg.sv
package rob_pkg;

`include "rob_cfg.svh"

  // Entry index, doubles as the commit id
  typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

  // One bit per dispatch slot
  typedef logic [`DISP_W-1:0] grp_mask_t;

  typedef logic [`SLOT_W-1:0] slot_idx_t;  // Slot number within a group

  // Commit sequencing
  typedef enum logic {
    COMMIT_RUN  = 1'b0,
    COMMIT_KILL = 1'b1
  } commit_state_t;

endpackage

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_rob -f compile.f -o tb_rob \
  && ./obj_dir/tb_rob \
  || { echo "simulation run reported a failure"; exit 1; }

//--- verification/tb_rob.sv
`timescale 1ns/1ps

`include "rob_cfg.svh"

module tb_rob import exc_pkg::*, rob_pkg::*; ();

  typedef struct packed {
    rob_idx_t              id;
    logic [`PC_W-1:0]      pc;
    grp_mask_t             grp;
    grp_mask_t             done;
    grp_mask_t             dead;
    grp_mask_t             exc;
    grp_mask_t             tval_chk;  // Trap value known from a completion
    except_t [`DISP_W-1:0] cause;
    tval_t [`DISP_W-1:0]   tval;
  } group_t;

  logic i_clk, i_reset_n, i_disp_valid;
  logic [`PC_W-1:0] i_disp_pc;
  grp_mask_t i_disp_grp, i_disp_illegal, i_disp_fetch_fault;
  logic [`CMPL_PORTS-1:0] i_cmpl_valid, i_cmpl_except;
  rob_idx_t [`CMPL_PORTS-1:0] i_cmpl_id;
  slot_idx_t [`CMPL_PORTS-1:0] i_cmpl_slot;
  except_t [`CMPL_PORTS-1:0] i_cmpl_cause;
  tval_t [`CMPL_PORTS-1:0] i_cmpl_tval;
  rob_idx_t o_disp_id, o_commit_id;
  logic o_full, o_commit_valid, o_commit_except, o_kill;
  logic [`PC_W-1:0] o_commit_pc;
  grp_mask_t o_commit_retire;
  except_t o_commit_cause;
  tval_t o_commit_tval;
  slot_idx_t o_commit_slot;

  logic [31:0] lfsr;
  group_t model_q [$];
  rob_idx_t tail_id;
  int cycle_cnt, full_cnt, kill_cnt, dead_cnt;

  rob u_dut (.*);

  always #50 i_clk = ~i_clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic step_cycle(input logic allow_disp);
    group_t g;
    grp_mask_t live, retire, grp, ill, ff, pend;
    logic found;
    int slot;
    int k;
    int enc;
    int cand [$];
    @(posedge i_clk);
    cycle_cnt++;
    found = 1'b0;
    if (o_commit_valid && model_q.size() == 0) begin
      $display("Test failed");
      $fatal(1, "commit seen with no group outstanding");
    end else if (o_commit_valid) begin
      g = model_q.pop_front();  // Oldest group must retire first
      pend = g.grp & ~(g.done | g.dead);
      check_value("o_commit_valid", o_commit_valid, pend == '0);  // Slots still executing
      live = g.grp & ~g.dead;
      retire = '0;
      slot = 0;
      for (int s = 0; s < `DISP_W; s++) begin
        if (!found && live[s] && g.exc[s]) begin
          found = 1'b1;
          slot = s;
        end else if (!found && live[s]) begin
          retire[s] = 1'b1;
        end
      end
      check_value("o_commit_id", o_commit_id, g.id);
      check_value("o_commit_pc", o_commit_pc, g.pc);
      check_value("o_commit_retire", o_commit_retire, retire);
      check_value("o_commit_except", o_commit_except, found);
      if (found) begin
        check_value("o_commit_cause", o_commit_cause, g.cause[slot]);
        check_value("o_commit_slot", o_commit_slot, slot);
        if (g.tval_chk[slot]) check_value("o_commit_tval", o_commit_tval, g.tval[slot]);
      end
      if (live == '0) dead_cnt++;
    end
    check_value("o_kill", o_kill, found);  // Rides with the trapping commit
    check_value("o_full", o_full, model_q.size() == `ROB_ENTRIES);
    check_value("o_disp_id", o_disp_id, tail_id);
    full_cnt += o_full;
    kill_cnt += o_kill;
    if (i_disp_valid) begin
      g = '0;
      g.id = tail_id;
      g.pc = i_disp_pc;
      g.grp = i_disp_grp;
      g.done = (i_disp_illegal | i_disp_fetch_fault) & i_disp_grp;
      g.exc = g.done;
      for (int s = 0; s < `DISP_W; s++) begin
        if (i_disp_fetch_fault[s]) g.cause[s] = EXC_FETCH_FAULT;  // Wins over illegal
        else if (i_disp_illegal[s]) g.cause[s] = EXC_ILLEGAL;
      end
      model_q.push_back(g);
      tail_id++;
    end
    for (int i = 0; i < model_q.size(); i++) begin
      g = model_q[i];
      if (o_kill) g.dead = '1;  // Also hits a group loaded under kill
      for (int p = 0; p < `CMPL_PORTS; p++) begin
        if (i_cmpl_valid[p] && i_cmpl_id[p] == g.id) begin
          g.done[i_cmpl_slot[p]] = 1'b1;
          g.exc[i_cmpl_slot[p]] = i_cmpl_except[p];
          g.cause[i_cmpl_slot[p]] = i_cmpl_cause[p];
          g.tval[i_cmpl_slot[p]] = i_cmpl_tval[p];
          g.tval_chk[i_cmpl_slot[p]] = i_cmpl_except[p];
        end
      end
      model_q[i] = g;
      for (int s = 0; s < `DISP_W; s++) begin
        if (g.grp[s] && !g.done[s] && !g.dead[s]) cand.push_back(int'(g.id) * `DISP_W + s);
      end
    end
    // Busy and idle phases alternate so the ROB fills up
    for (int p = 0; p < `CMPL_PORTS; p++) begin
      if (cand.size() > 0 && rand_bits(2) < (cycle_cnt[6] ? 1 : 3)) begin
        k = rand_bits(4) % cand.size();
        enc = cand[k];
        cand.delete(k);
        i_cmpl_valid[p]  <= 1'b1;
        i_cmpl_id[p]     <= rob_idx_t'(enc / `DISP_W);
        i_cmpl_slot[p]   <= slot_idx_t'(enc % `DISP_W);
        i_cmpl_except[p] <= (rand_bits(4) == 0);
        i_cmpl_cause[p]  <= except_t'(EXC_LOAD_FAULT + rand_bits(2) % 3);
        i_cmpl_tval[p]   <= rand_bits(`TVAL_W);
      end else begin
        i_cmpl_valid[p] <= 1'b0;
      end
    end
    if (allow_disp && model_q.size() < `ROB_ENTRIES && rand_bits(2) != 0) begin
      grp = grp_mask_t'(rand_bits(`DISP_W));
      if (grp == '0) grp = grp_mask_t'(1);
      for (int s = 0; s < `DISP_W; s++) begin
        ill[s] = (rand_bits(5) == 0);
        ff[s]  = (rand_bits(5) == 0);
      end
      i_disp_valid       <= 1'b1;
      i_disp_pc          <= rand_bits(`PC_W);
      i_disp_grp         <= grp;
      i_disp_illegal     <= ill & grp;
      i_disp_fetch_fault <= ff & grp;
    end else begin
      i_disp_valid <= 1'b0;
    end
  endtask

  initial begin
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    lfsr = 32'hc3a8;
    tail_id = '0;
    i_disp_valid = 1'b0;
    i_disp_pc = '0;
    i_disp_grp = '0;
    i_disp_illegal = '0;
    i_disp_fetch_fault = '0;
    i_cmpl_valid = '0;
    i_cmpl_id = '0;
    i_cmpl_slot = '0;
    i_cmpl_except = '0;
    i_cmpl_tval = '0;
    for (int p = 0; p < `CMPL_PORTS; p++) begin
      i_cmpl_cause[p] = EXC_NONE;
    end
    cycle_cnt = 0;
    full_cnt = 0;
    kill_cnt = 0;
    dead_cnt = 0;
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(posedge i_clk);
    check_value("o_commit_valid", o_commit_valid, 0);
    check_value("o_kill", o_kill, 0);
    check_value("o_full", o_full, 0);
    check_value("o_disp_id", o_disp_id, 0);
    for (int n = 0; n < 4000; n++) begin
      step_cycle(1'b1);
    end
    // Drain what is left within a bound
    for (int n = 0; n < 500 && model_q.size() != 0; n++) begin
      step_cycle(1'b0);
    end
    if (model_q.size() != 0) begin
      $display("Test failed");
      $fatal(1, "timeout: %0d groups never committed", model_q.size());
    end else if (full_cnt == 0 || kill_cnt == 0 || dead_cnt == 0) begin
      $display("Test failed");
      $fatal(1, "stimulus never reached a full ROB, a kill or a dead group commit");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule
